//--- include/sd_host_macros.svh
/*
 * SD host data path constants
 * Register map, field bit positions and block timing
 */
`ifndef SD_HOST_MACROS_SVH
`define SD_HOST_MACROS_SVH

// Register byte addresses
`define SD_ADDR_TRANSFER_MODE     8'h0C
`define SD_ADDR_PRESENT_STATE     8'h24
`define SD_ADDR_NORMAL_INT_STATUS 8'h30

// Field bit positions
`define SD_TM_DIR_BIT             4
`define SD_PSR_CMD_INHIBIT_DAT    1
`define SD_PSR_WR_ACTIVE          8
`define SD_PSR_RD_ACTIVE          9
`define SD_NISR_TF_COMPLETE       1

// Block shape and register width
`define SD_BLOCK_WORDS            4
`define SD_CRC_CYCLES             3
`define SD_REG_WIDTH              32

`endif

//--- verilog/sd_host_pkg.sv
/*
 * SD host data path types
 * Data FSM states, register selects and transfer direction
 */
`default_nettype none

package sd_host_pkg;

   ////////////////////////////////////////
   // Data control FSM, one-hot
   ////////////////////////////////////////
   typedef enum logic [4:0] {
      IDLE           = 5'b00001,
      WRITE_START    = 5'b00010,
      READ_START     = 5'b00100,
      READ_TRANSFER  = 5'b01000,
      WRITE_TRANSFER = 5'b10000
   } dat_state_t;

   // Register selected by a host read
   typedef enum logic [2:0] {
      REG_NONE              = 3'd0,
      REG_TRANSFER_MODE     = 3'd1,
      REG_PRESENT_STATE     = 3'd2,
      REG_NORMAL_INT_STATUS = 3'd3
   } reg_sel_t;

   // Transfer Mode direction bit
   typedef enum logic {
      DIR_WRITE = 1'b0,
      DIR_READ  = 1'b1
   } tf_dir_t;

endpackage

`default_nettype wire

//--- verilog/sd_dat_status_if.sv
/*
 * Status update bundle
 * Carries Present State and interrupt status updates from the data FSM
 */
`timescale 1ns/1ps
`default_nettype none

interface sd_dat_status_if;

   // Present State values and per-bit write enables
   // bit 0 cmd inhibit, bit 1 write active, bit 2 read active
   logic       wr_tf_active;
   logic       rd_tf_active;
   logic       cmd_inhibit_dat;
   logic [2:0] psr_wr_enb;

   // Transfer Complete set request
   logic       tf_complete;
   logic       nisr_wr_enb;

   modport ctrl (
      output wr_tf_active, rd_tf_active, cmd_inhibit_dat, psr_wr_enb,
      output tf_complete, nisr_wr_enb
   );

   modport regs (
      input  wr_tf_active, rd_tf_active, cmd_inhibit_dat, psr_wr_enb,
      input  tf_complete, nisr_wr_enb
   );

endinterface

`default_nettype wire

//--- verilog/host_reg_decode.sv
/*
 * Host register decode
 * Maps host accesses onto register selects and holds Transfer Mode
 */
`timescale 1ns/1ps
`default_nettype none
`include "sd_host_macros.svh"

module host_reg_decode
   import sd_host_pkg::*;
(
   input  logic                     host_clk,
   input  logic                     rst_L,
   input  logic                     reg_wr,
   input  logic                     reg_rd,
   input  logic [7:0]               reg_addr,
   input  logic [`SD_REG_WIDTH-1:0] reg_wdata,
   output reg_sel_t                 rd_sel,
   output logic [`SD_REG_WIDTH-1:0] nisr_w1c,
   output logic [`SD_REG_WIDTH-1:0] tf_mode,
   output tf_dir_t                  tf_direction
);

   reg_sel_t addr_sel;

   // Address map lookup
   always_comb begin
      case (reg_addr)
         `SD_ADDR_TRANSFER_MODE:     addr_sel = REG_TRANSFER_MODE;
         `SD_ADDR_PRESENT_STATE:     addr_sel = REG_PRESENT_STATE;
         `SD_ADDR_NORMAL_INT_STATUS: addr_sel = REG_NORMAL_INT_STATUS;
         default:                    addr_sel = REG_NONE;
      endcase
   end

   // Read select held for the data return cycle, Transfer Mode storage
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         rd_sel  <= REG_NONE;
         tf_mode <= '0;
      end else begin
         rd_sel <= reg_rd ? addr_sel : REG_NONE;
         if (reg_wr && addr_sel == REG_TRANSFER_MODE) begin
            tf_mode <= reg_wdata;
         end
      end
   end

   // Write-1-to-clear bits toward the interrupt status
   assign nisr_w1c = (reg_wr && addr_sel == REG_NORMAL_INT_STATUS) ? reg_wdata : '0;

   assign tf_direction = tf_dir_t'(tf_mode[`SD_TM_DIR_BIT]);

endmodule

`default_nettype wire

//--- verilog/dat_control.sv
/*
 * Data line transfer control
 * Starts a block after the command response, strobes the buffers
 * and posts Present State and Transfer Complete updates
 */
`timescale 1ns/1ps
`default_nettype none

module dat_control
   import sd_host_pkg::*;
(
   input  logic            host_clk,
   input  logic            rst_L,
   input  tf_dir_t         tf_direction,
   input  logic            resp_recv,
   input  logic            tx_buf_empty,
   input  logic            rx_buf_full,
   input  logic            tf_finished,
   input  logic            dat_phys_busy,
   output logic            dat_wr_flag,
   output logic            dat_rd_flag,
   sd_dat_status_if.ctrl   stat
);

   dat_state_t state;
   dat_state_t nxt_state;
   logic       wr_valid;
   logic       rd_valid;

   // Buffer holds a word and the line is free
   assign wr_valid = !tx_buf_empty && !dat_phys_busy;
   assign rd_valid = !rx_buf_full && !dat_phys_busy;

   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         state <= IDLE;
      end else begin
         state <= nxt_state;
      end
   end

   ////////////////////////////////////////
   // Next state and Mealy outputs
   ////////////////////////////////////////
   always_comb begin
      nxt_state            = state;
      dat_wr_flag          = 1'b0;
      dat_rd_flag          = 1'b0;
      stat.wr_tf_active    = 1'b0;
      stat.rd_tf_active    = 1'b0;
      stat.cmd_inhibit_dat = 1'b0;
      stat.psr_wr_enb      = 3'b000;
      stat.tf_complete     = 1'b0;
      stat.nisr_wr_enb     = 1'b0;

      case (state)
         IDLE: begin
            if (resp_recv) begin
               nxt_state = (tf_direction == DIR_READ) ? READ_START : WRITE_START;
            end
         end

         WRITE_START: begin
            // First pop together with the active and inhibit bits
            if (wr_valid) begin
               nxt_state            = WRITE_TRANSFER;
               dat_wr_flag          = 1'b1;
               stat.wr_tf_active    = 1'b1;
               stat.cmd_inhibit_dat = 1'b1;
               stat.psr_wr_enb      = 3'b011;
            end
         end

         READ_START: begin
            if (rd_valid) begin
               nxt_state            = READ_TRANSFER;
               dat_rd_flag          = 1'b1;
               stat.rd_tf_active    = 1'b1;
               stat.cmd_inhibit_dat = 1'b1;
               stat.psr_wr_enb      = 3'b101;
            end
         end

         READ_TRANSFER: begin
            if (!tf_finished) begin
               // Push only while there is room and the block is still open
               dat_rd_flag = rd_valid;
            end else begin
               // Drop read active and inhibit, flag completion
               stat.psr_wr_enb  = 3'b101;
               stat.tf_complete = 1'b1;
               stat.nisr_wr_enb = 1'b1;
               nxt_state        = IDLE;
            end
         end

         WRITE_TRANSFER: begin
            if (!tf_finished) begin
               dat_wr_flag = wr_valid;
            end else begin
               stat.psr_wr_enb  = 3'b011;
               stat.tf_complete = 1'b1;
               stat.nisr_wr_enb = 1'b1;
               nxt_state        = IDLE;
            end
         end

         default: begin
            nxt_state = IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/dat_phys_engine.sv
/*
 * Data line engine
 * Counts the words of a block, stays busy for the CRC phase
 * and pulses tf_finished when the block is done
 */
`timescale 1ns/1ps
`default_nettype none
`include "sd_host_macros.svh"

module dat_phys_engine (
   input  logic host_clk,
   input  logic rst_L,
   input  logic dat_wr_flag,
   input  logic dat_rd_flag,
   output logic dat_phys_busy,
   output logic tf_finished
);

   localparam int WORD_CW = $clog2(`SD_BLOCK_WORDS + 1);
   localparam int CRC_CW  = $clog2(`SD_CRC_CYCLES + 1);

   localparam logic [WORD_CW-1:0] LAST_WORD = WORD_CW'(`SD_BLOCK_WORDS - 1);
   localparam logic [CRC_CW-1:0]  LAST_CRC  = CRC_CW'(`SD_CRC_CYCLES - 1);

   logic [WORD_CW-1:0] word_cnt;
   logic [CRC_CW-1:0]  crc_cnt;
   logic               word_strobe;

   // Either buffer strobe moves one word on the line
   assign word_strobe = dat_wr_flag | dat_rd_flag;

   ////////////////////////////////////////
   // Word and CRC counters
   ////////////////////////////////////////
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         word_cnt      <= '0;
         crc_cnt       <= '0;
         dat_phys_busy <= 1'b0;
         tf_finished   <= 1'b0;
      end else begin
         tf_finished <= 1'b0;
         if (!dat_phys_busy) begin
            if (word_strobe) begin
               if (word_cnt == LAST_WORD) begin
                  // Last word, line goes busy for CRC
                  word_cnt      <= '0;
                  crc_cnt       <= '0;
                  dat_phys_busy <= 1'b1;
               end else begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
         end else begin
            if (crc_cnt == LAST_CRC) begin
               // CRC phase over, one cycle finish pulse
               crc_cnt       <= '0;
               dat_phys_busy <= 1'b0;
               tf_finished   <= 1'b1;
            end else begin
               crc_cnt <= crc_cnt + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/host_status_regs.sv
/*
 * Host status registers
 * Present State and Normal Interrupt Status bits plus read data return
 */
`timescale 1ns/1ps
`default_nettype none
`include "sd_host_macros.svh"

module host_status_regs
   import sd_host_pkg::*;
(
   input  logic                     host_clk,
   input  logic                     rst_L,
   sd_dat_status_if.regs            stat,
   input  reg_sel_t                 rd_sel,
   input  logic [`SD_REG_WIDTH-1:0] nisr_w1c,
   input  logic [`SD_REG_WIDTH-1:0] tf_mode,
   output logic [`SD_REG_WIDTH-1:0] reg_rdata
);

   logic                     cmd_inhibit_dat;
   logic                     wr_active;
   logic                     rd_active;
   logic                     tf_complete;
   logic [`SD_REG_WIDTH-1:0] present_state;
   logic [`SD_REG_WIDTH-1:0] normal_int_status;

   ////////////////////////////////////////
   // Present State bits
   ////////////////////////////////////////
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         cmd_inhibit_dat <= 1'b0;
         wr_active       <= 1'b0;
         rd_active       <= 1'b0;
      end else begin
         if (stat.psr_wr_enb[0]) begin
            cmd_inhibit_dat <= stat.cmd_inhibit_dat;
         end
         if (stat.psr_wr_enb[1]) begin
            wr_active <= stat.wr_tf_active;
         end
         if (stat.psr_wr_enb[2]) begin
            rd_active <= stat.rd_tf_active;
         end
      end
   end

   // Transfer Complete, a new set beats a host clear
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         tf_complete <= 1'b0;
      end else if (stat.nisr_wr_enb && stat.tf_complete) begin
         tf_complete <= 1'b1;
      end else if (nisr_w1c[`SD_NISR_TF_COMPLETE]) begin
         tf_complete <= 1'b0;
      end
   end

   always_comb begin
      present_state                          = '0;
      present_state[`SD_PSR_CMD_INHIBIT_DAT] = cmd_inhibit_dat;
      present_state[`SD_PSR_WR_ACTIVE]       = wr_active;
      present_state[`SD_PSR_RD_ACTIVE]       = rd_active;
      normal_int_status                      = '0;
      normal_int_status[`SD_NISR_TF_COMPLETE] = tf_complete;
   end

   // Read data follows the select registered in the decode
   always_comb begin
      case (rd_sel)
         REG_TRANSFER_MODE:     reg_rdata = tf_mode;
         REG_PRESENT_STATE:     reg_rdata = present_state;
         REG_NORMAL_INT_STATUS: reg_rdata = normal_int_status;
         default:               reg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/sd_dat_top.sv
/*
 * SD host data transfer control, top level
 * Register decode, data FSM, line engine and status registers
 */
`timescale 1ns/1ps
`default_nettype none
`include "sd_host_macros.svh"

module sd_dat_top
   import sd_host_pkg::*;
(
   input  logic                     host_clk,
   input  logic                     rst_L,
   input  logic                     reg_wr,
   input  logic                     reg_rd,
   input  logic [7:0]               reg_addr,
   input  logic [`SD_REG_WIDTH-1:0] reg_wdata,
   output logic [`SD_REG_WIDTH-1:0] reg_rdata,
   input  logic                     resp_recv,
   input  logic                     tx_buf_empty,
   input  logic                     rx_buf_full,
   output logic                     dat_wr_flag,
   output logic                     dat_rd_flag
);

   reg_sel_t                 rd_sel;
   tf_dir_t                  tf_direction;
   logic [`SD_REG_WIDTH-1:0] nisr_w1c;
   logic [`SD_REG_WIDTH-1:0] tf_mode;
   logic                     dat_phys_busy;
   logic                     tf_finished;

   sd_dat_status_if stat_if ();

   host_reg_decode u_decode (
      .host_clk, .rst_L, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
      .rd_sel, .nisr_w1c, .tf_mode, .tf_direction
   );

   dat_control u_dat_control (
      .host_clk, .rst_L, .tf_direction, .resp_recv, .tx_buf_empty, .rx_buf_full,
      .tf_finished, .dat_phys_busy, .dat_wr_flag, .dat_rd_flag, .stat(stat_if.ctrl)
   );

   dat_phys_engine u_phys (
      .host_clk, .rst_L, .dat_wr_flag, .dat_rd_flag, .dat_phys_busy, .tf_finished
   );

   host_status_regs u_status (
      .host_clk, .rst_L, .stat(stat_if.regs), .rd_sel, .nisr_w1c, .tf_mode, .reg_rdata
   );

endmodule

`default_nettype wire

//--- verification/tb_sd_dat_top.sv
/*
 * Testbench for the SD host data transfer control
 * Random buffer stalls and directions, checked against a register model
 */
`timescale 1ns/1ps
`default_nettype none
`include "sd_host_macros.svh"

module tb_sd_dat_top
   import sd_host_pkg::*;
();

   localparam int WAIT_LIMIT = 500;
   localparam logic [7:0] ADDR_UNMAPPED = 8'h40;

   logic                     host_clk = 1'b0;
   logic                     rst_L = 1'b0;
   logic                     reg_wr = 1'b0;
   logic                     reg_rd = 1'b0;
   logic [7:0]               reg_addr = '0;
   logic [`SD_REG_WIDTH-1:0] reg_wdata = '0;
   logic [`SD_REG_WIDTH-1:0] reg_rdata;
   logic                     resp_recv = 1'b0;
   logic                     tx_buf_empty = 1'b0;
   logic                     rx_buf_full = 1'b0;
   logic                     dat_wr_flag;
   logic                     dat_rd_flag;

   // Model state
   int                       pop_total = 0;
   int                       push_total = 0;
   logic                     stall_en = 1'b0;
   logic                     tc_exp = 1'b0;
   logic [`SD_REG_WIDTH-1:0] tm_exp = '0;

   always #10 host_clk = ~host_clk;

   sd_dat_top uut (
      .host_clk, .rst_L, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata,
      .resp_recv, .tx_buf_empty, .rx_buf_full, .dat_wr_flag, .dat_rd_flag
   );

   task automatic fail_run(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_reg(input string name, input logic [`SD_REG_WIDTH-1:0] got,
                            input logic [`SD_REG_WIDTH-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   ////////////////////////////////////////
   // Strobe monitor and buffer stalls
   ////////////////////////////////////////
   always @(posedge host_clk) begin
      if (rst_L) begin
         if (dat_wr_flag && tx_buf_empty) begin
            fail_run("pop strobe seen while the transmit buffer was empty");
         end
         if (dat_rd_flag && rx_buf_full) begin
            fail_run("push strobe seen while the receive buffer was full");
         end
         if (dat_wr_flag) pop_total = pop_total + 1;
         if (dat_rd_flag) push_total = push_total + 1;
      end
   end

   always @(negedge host_clk) begin
      if (stall_en) begin
         tx_buf_empty = ($urandom_range(2, 0) == 0);
         rx_buf_full  = ($urandom_range(2, 0) == 0);
      end else begin
         tx_buf_empty = 1'b0;
         rx_buf_full  = 1'b0;
      end
   end

   // Host bus accesses start and end just after a falling edge
   task automatic write_reg(input logic [7:0] addr, input logic [`SD_REG_WIDTH-1:0] data);
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge host_clk);
      reg_wr = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [`SD_REG_WIDTH-1:0] data);
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(negedge host_clk);
      data   = reg_rdata;
      reg_rd = 1'b0;
   endtask

   task automatic expect_reg(input string name, input logic [7:0] addr,
                             input logic [`SD_REG_WIDTH-1:0] exp);
      logic [`SD_REG_WIDTH-1:0] data;
      read_reg(addr, data);
      check_reg(name, data, exp);
   endtask

   task automatic run_transfer(input tf_dir_t dir);
      logic [`SD_REG_WIDTH-1:0] tm;
      logic [`SD_REG_WIDTH-1:0] busy_psr;
      logic [`SD_REG_WIDTH-1:0] nisr;
      int                       pop_base;
      int                       push_base;
      int                       guard;
      tm = $urandom;
      tm[`SD_TM_DIR_BIT] = (dir == DIR_READ);
      write_reg(`SD_ADDR_TRANSFER_MODE, tm);
      tm_exp = tm;
      write_reg(`SD_ADDR_NORMAL_INT_STATUS, 32'h1 << `SD_NISR_TF_COMPLETE);
      tc_exp = 1'b0;
      busy_psr = 32'h1 << `SD_PSR_CMD_INHIBIT_DAT;
      busy_psr[(dir == DIR_READ) ? `SD_PSR_RD_ACTIVE : `SD_PSR_WR_ACTIVE] = 1'b1;
      pop_base  = pop_total;
      push_base = push_total;
      stall_en  = 1'b1;
      resp_recv = 1'b1;
      @(negedge host_clk);
      resp_recv = 1'b0;
      guard = 0;
      while (pop_total == pop_base && push_total == push_base && guard < WAIT_LIMIT) begin
         @(negedge host_clk);
         guard++;
      end
      if (guard >= WAIT_LIMIT) fail_run("timed out waiting for the first buffer strobe");
      // Block still running so the status bits show it
      expect_reg("present_state", `SD_ADDR_PRESENT_STATE, busy_psr);
      guard = 0;
      nisr  = '0;
      while (nisr[`SD_NISR_TF_COMPLETE] !== 1'b1 && guard < WAIT_LIMIT) begin
         read_reg(`SD_ADDR_NORMAL_INT_STATUS, nisr);
         guard++;
      end
      if (guard >= WAIT_LIMIT) fail_run("timed out waiting for Transfer Complete");
      tc_exp   = 1'b1;
      stall_en = 1'b0;
      check_count("pop_strobes", pop_total - pop_base,
                  (dir == DIR_WRITE) ? `SD_BLOCK_WORDS : 0);
      check_count("push_strobes", push_total - push_base,
                  (dir == DIR_READ) ? `SD_BLOCK_WORDS : 0);
      expect_reg("present_state", `SD_ADDR_PRESENT_STATE, '0);
      expect_reg("normal_int_status", `SD_ADDR_NORMAL_INT_STATUS,
                 32'(tc_exp) << `SD_NISR_TF_COMPLETE);
      expect_reg("transfer_mode", `SD_ADDR_TRANSFER_MODE, tm_exp);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial begin
      logic [`SD_REG_WIDTH-1:0] val;
      void'($urandom(32'h3a5));
      repeat (3) @(negedge host_clk);
      rst_L = 1'b1;

      // Reset values
      expect_reg("transfer_mode", `SD_ADDR_TRANSFER_MODE, '0);
      expect_reg("present_state", `SD_ADDR_PRESENT_STATE, '0);
      expect_reg("normal_int_status", `SD_ADDR_NORMAL_INT_STATUS, '0);
      check_count("pop_strobes", pop_total, 0);
      check_count("push_strobes", push_total, 0);

      run_transfer(DIR_WRITE);
      run_transfer(DIR_READ);

      // Write 1 clears the flag while zeros leave it alone
      val = $urandom;
      val[`SD_NISR_TF_COMPLETE] = 1'b0;
      write_reg(`SD_ADDR_NORMAL_INT_STATUS, val);
      expect_reg("normal_int_status", `SD_ADDR_NORMAL_INT_STATUS,
                 32'(tc_exp) << `SD_NISR_TF_COMPLETE);
      write_reg(`SD_ADDR_NORMAL_INT_STATUS, 32'h1 << `SD_NISR_TF_COMPLETE);
      tc_exp = 1'b0;
      expect_reg("normal_int_status", `SD_ADDR_NORMAL_INT_STATUS, '0);

      // Transfer Mode readback and an unmapped address
      val = $urandom;
      write_reg(`SD_ADDR_TRANSFER_MODE, val);
      tm_exp = val;
      write_reg(ADDR_UNMAPPED, $urandom);
      expect_reg("transfer_mode", `SD_ADDR_TRANSFER_MODE, tm_exp);
      expect_reg("unmapped", ADDR_UNMAPPED, '0);

      for (int i = 0; i < 6; i++) begin
         run_transfer(tf_dir_t'($urandom_range(1, 0)));
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
verilog/sd_host_pkg.sv
verilog/sd_dat_status_if.sv
verilog/host_reg_decode.sv
verilog/dat_control.sv
verilog/dat_phys_engine.sv
verilog/host_status_regs.sv
verilog/sd_dat_top.sv
verification/tb_sd_dat_top.sv

//--- Makefile
# Verilator simulation of the SD host data transfer control

VERILATOR ?= verilator
TOP       ?= tb_sd_dat_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
